/* logic/conv_consts.svh */
// engine sizes; widths must satisfy conv_word_out >= 2*conv_word_in and conv_lat_mul >= 1.
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// pixel lanes processed side by side, one output sum per lane.
`define CONV_UNITS 4

// signed pixel and weight width.
`define CONV_WORD_IN 8

// accumulator width, sums wrap modulo 2**CONV_WORD_OUT.
`define CONV_WORD_OUT 24

// multiplier pipeline depth in enabled cycles.
// the flag delay line uses the same depth so control stays aligned.
`define CONV_LAT_MUL 3

`endif

/* logic/conv_data_pkg.sv */
// datapath word types; all widths come from conv_consts.svh and nothing here is configurable.
`include "conv_consts.svh"

package conv_data_pkg;

  // input words, two's complement.
  typedef logic signed [`CONV_WORD_IN-1:0] pixel_t;
  typedef logic signed [`CONV_WORD_IN-1:0] weight_t;

  // full precision product of one pixel and one weight.
  typedef logic signed [2*`CONV_WORD_IN-1:0] product_t;

  // running sum per lane.
  typedef logic signed [`CONV_WORD_OUT-1:0] sum_t;

  // one element per lane, lane 0 sits in the low bits of the flat buses.
  typedef pixel_t pixel_vec_t [`CONV_UNITS];
  typedef product_t product_vec_t [`CONV_UNITS];
  typedef sum_t sum_vec_t [`CONV_UNITS];

endpackage

/* logic/conv_ctrl_pkg.sv */
// control types for the beat flags and accumulator sequencing; 1x1 kernels only.
package conv_ctrl_pkg;

  // flags that ride along with every input beat.
  typedef struct packed {
    logic valid;    // beat carries pixels and a weight.
    logic cin_last; // last input channel of the pixel group.
    logic last;     // last group of the image.
  } beat_flags_t;

  // what the accumulators do with the next product beat.
  typedef enum logic {
    ST_FRESH, // next product starts a new sum.
    ST_SUM    // next product adds onto the running sum.
  } acc_state_e;

endpackage

/* logic/acc_ctrl_if.sv */
// accumulator control bundle; all four signals are combinational from the sequencer.
`timescale 1ns/1ns

interface acc_ctrl_if;

  logic acc_en;   // a product beat is at the accumulator inputs.
  logic bypass;   // load the product, drop the old sum.
  logic sum_done; // this beat finishes the sums.
  logic sum_last; // finished sums close the image.

  // sequencer side.
  modport ctrl (
    output acc_en,
    output bypass,
    output sum_done,
    output sum_last
  );

  // accumulator side.
  modport acc (
    input acc_en,
    input bypass,
    input sum_done,
    input sum_last
  );

endinterface

/* logic/flag_delay.sv */
// flag delay line matched to the multiplier depth; advances only with clken, cin_last gated by valid.
`timescale 1ns/1ns
`include "conv_consts.svh"

module flag_delay
  import conv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        clken,
  input  logic        reset,
  input  beat_flags_t flags_in,
  output beat_flags_t flags_out
);

  // one stage per multiplier register, stage 0 takes the new beat.
  beat_flags_t stage [`CONV_LAT_MUL];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CONV_LAT_MUL; i++) begin
        stage[i] <= '0; // pipeline empty after reset.
      end
    end else if (clken) begin
      stage[0] <= flags_in;
      for (int i = 1; i < `CONV_LAT_MUL; i++) begin
        stage[i] <= stage[i-1]; // same shift as the product pipe.
      end
    end
  end

  // lines up with products at the multiplier output.
  assign flags_out = stage[`CONV_LAT_MUL-1];

  // the top gates cin_last with valid, so a bare cin_last means a broken stage.
  a_cin_last_valid : assert property (
    @(posedge clk) disable iff (reset)
    flags_out.cin_last |-> flags_out.valid
  ) else $error("flag_delay: cin_last left the delay line without valid");

endmodule

/* logic/acc_sequencer.sv */
// accumulator sequencer; assumes last only ever comes on a cin_last beat.
`timescale 1ns/1ns

module acc_sequencer
  import conv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        clken,
  input  logic        reset,
  input  beat_flags_t flags,
  acc_ctrl_if.ctrl    ctrl
);

  acc_state_e state;
  acc_state_e state_next;

  // next state only matters on a valid beat.
  always_comb begin
    if (flags.cin_last) begin
      state_next = ST_FRESH; // group closes, next beat starts over.
    end else begin
      state_next = ST_SUM;   // more channels to come.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FRESH;
    end else if (clken && flags.valid) begin
      state <= state_next; // idle cycles leave the state alone.
    end
  end

  // controls are plain decodes of the delayed flags.
  assign ctrl.acc_en   = flags.valid;
  assign ctrl.bypass   = (state == ST_FRESH);       // first channel of a group.
  assign ctrl.sum_done = flags.valid & flags.cin_last;
  assign ctrl.sum_last = flags.valid & flags.last;  // image end rides with the sum.

  // image end has to land on a finished group, else m_last is lost.
  a_last_on_done : assert property (
    @(posedge clk) disable iff (reset)
    ctrl.sum_last |-> ctrl.sum_done
  ) else $error("acc_sequencer: image end flagged on a beat that does not finish a sum");

endmodule

/* logic/multiplier_array.sv */
// lane multipliers; no reset, products are only meaningful where the delayed valid is set.
`timescale 1ns/1ns
`include "conv_consts.svh"

module multiplier_array
  import conv_data_pkg::*;
(
  input  logic         clk,
  input  logic         clken,
  input  pixel_vec_t   pixels,
  input  weight_t      weight,
  output product_vec_t products
);

  // pipe[0] holds the raw product, the rest just carry it.
  product_vec_t pipe [`CONV_LAT_MUL];

  always_ff @(posedge clk) begin
    if (clken) begin
      for (int u = 0; u < `CONV_UNITS; u++) begin
        pipe[0][u] <= pixels[u] * weight; // signed by signed, full width.
      end
      for (int s = 1; s < `CONV_LAT_MUL; s++) begin
        pipe[s] <= pipe[s-1];
      end
    end
  end

  // one shared weight for every lane.
  // products leave CONV_LAT_MUL enabled cycles after the beat.
  assign products = pipe[`CONV_LAT_MUL-1];

endmodule

/* logic/accumulator_array.sv */
// lane accumulators; sums wrap modulo 2**CONV_WORD_OUT and output has no backpressure.
`timescale 1ns/1ns
`include "conv_consts.svh"

module accumulator_array
  import conv_data_pkg::*;
(
  input  logic         clk,
  input  logic         clken,
  input  logic         reset,
  input  product_vec_t products,
  acc_ctrl_if.acc      ctrl,
  output logic         m_valid,
  output logic         m_last,
  output sum_vec_t     m_data
);

  sum_vec_t sum_q;    // running sums.
  sum_vec_t sum_next; // sums after this beat.
  logic     out_flag; // output register holds a fresh beat.

  always_comb begin
    for (int u = 0; u < `CONV_UNITS; u++) begin
      if (ctrl.bypass) begin
        sum_next[u] = sum_t'(products[u]);              // sign extended load.
      end else begin
        sum_next[u] = sum_q[u] + sum_t'(products[u]);   // wraps on overflow.
      end
    end
  end

  // sums and output words.
  always_ff @(posedge clk) begin
    if (clken && ctrl.acc_en) begin
      sum_q <= sum_next;
    end
    if (clken && ctrl.sum_done) begin
      m_data <= sum_next; // finished group goes out on the same edge.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_flag <= 1'b0;
      m_last   <= 1'b0;
    end else if (clken) begin
      out_flag <= ctrl.sum_done; // held for one enabled cycle.
      if (ctrl.sum_done) begin
        m_last <= ctrl.sum_last;
      end
    end
  end

  // a stalled cycle must not count as a second transfer.
  assign m_valid = out_flag & clken;

  // a finished group needs its last product at the inputs.
  a_done_with_product : assert property (
    @(posedge clk) disable iff (reset)
    ctrl.sum_done |-> ctrl.acc_en
  ) else $error("accumulator_array: sums finished without a product beat");

endmodule

/* logic/conv_engine.sv */
// 1x1 conv engine top; clken is the only flow control, the consumer cannot stall m_valid.
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_engine
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  clken,
  input  logic                                  reset,
  input  logic                                  s_valid,
  input  logic                                  s_cin_last,
  input  logic                                  s_last,
  input  logic [`CONV_UNITS*`CONV_WORD_IN-1:0]  s_pixels,
  input  logic [`CONV_WORD_IN-1:0]              s_weight,
  output logic                                  s_ready,
  output logic                                  m_valid,
  output logic                                  m_last,
  output logic [`CONV_UNITS*`CONV_WORD_OUT-1:0] m_data
);

  pixel_vec_t   pixels;
  product_vec_t products;
  sum_vec_t     sums;
  beat_flags_t  in_flags;
  beat_flags_t  mul_flags; // flags aligned with products.

  acc_ctrl_if acc_ctrl ();

  // input taken whenever the engine runs.
  assign s_ready = clken;

  // strobes only count on a valid beat.
  assign in_flags.valid    = s_valid;
  assign in_flags.cin_last = s_valid & s_cin_last;
  assign in_flags.last     = s_valid & s_last;

  // lane u lives at bits u*width.
  for (genvar u = 0; u < `CONV_UNITS; u++) begin : g_lane
    assign pixels[u] = s_pixels[u*`CONV_WORD_IN +: `CONV_WORD_IN];
    assign m_data[u*`CONV_WORD_OUT +: `CONV_WORD_OUT] = sums[u];
  end

  multiplier_array i_multiplier_array (
    .clk      (clk),
    .clken    (clken),
    .pixels   (pixels),
    .weight   (s_weight),
    .products (products)
  );

  flag_delay i_flag_delay (
    .clk       (clk),
    .clken     (clken),
    .reset     (reset),
    .flags_in  (in_flags),
    .flags_out (mul_flags)
  );

  acc_sequencer i_acc_sequencer (
    .clk   (clk),
    .clken (clken),
    .reset (reset),
    .flags (mul_flags),
    .ctrl  (acc_ctrl.ctrl)
  );

  accumulator_array i_accumulator_array (
    .clk      (clk),
    .clken    (clken),
    .reset    (reset),
    .products (products),
    .ctrl     (acc_ctrl.acc),
    .m_valid  (m_valid),
    .m_last   (m_last),
    .m_data   (sums)
  );

endmodule

/* dv/conv_checker.sv */
// output monitor for conv_engine; results must arrive in file order, one entry per output beat.
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_checker (
  input logic                                  clk,
  input logic                                  reset,
  input logic                                  clken,
  input logic                                  s_ready,
  input logic                                  m_valid,
  input logic                                  m_last,
  input logic [`CONV_UNITS*`CONV_WORD_OUT-1:0] m_data
);

  logic                                  exp_last_q [$]; // expected image-end flags.
  logic [`CONV_UNITS*`CONV_WORD_OUT-1:0] exp_data_q [$]; // expected flat sums.

  int mismatches = 0;
  int unexpected = 0; // output beats with nothing queued.
  int beats_seen = 0;

  // called by the testbench for every E line.
  task automatic push_expected(input logic last,
                               input logic [`CONV_UNITS*`CONV_WORD_OUT-1:0] data);
    exp_last_q.push_back(last);
    exp_data_q.push_back(data);
  endtask

  function automatic int pending_count();
    return exp_data_q.size();
  endfunction

  // leftover entries count as missing outputs.
  task automatic final_counts(output int mism, output int unexp, output int missing);
    missing = exp_data_q.size();
    if (missing != 0) begin
      $display("error: %0d expected output beats never arrived", missing);
    end
    mism  = mismatches;
    unexp = unexpected;
  endtask

  // compares one output beat against the oldest expectation.
  task automatic check_beat();
    logic                                  exp_last;
    logic [`CONV_UNITS*`CONV_WORD_OUT-1:0] exp_data;
    logic [`CONV_WORD_OUT-1:0]             got;
    logic [`CONV_WORD_OUT-1:0]             want;
    beats_seen++;
    if (exp_data_q.size() == 0) begin
      $display("error: output beat %0d at %0t ns came with no result expected",
               beats_seen, $time);
      unexpected++;
    end else begin
      exp_last = exp_last_q.pop_front();
      exp_data = exp_data_q.pop_front();
      for (int u = 0; u < `CONV_UNITS; u++) begin
        got  = m_data[u*`CONV_WORD_OUT +: `CONV_WORD_OUT];
        want = exp_data[u*`CONV_WORD_OUT +: `CONV_WORD_OUT];
        if (got !== want) begin
          $display("MISMATCH at %0t ns: beat %0d lane %0d sum %06h, expected %06h",
                   $time, beats_seen, u, got, want);
          mismatches++;
        end
      end
      if (m_last !== exp_last) begin
        $display("MISMATCH at %0t ns: beat %0d m_last %0b, expected %0b",
                 $time, beats_seen, m_last, exp_last);
        mismatches++;
      end
    end
  endtask

  // input side follows the enable, each m_valid edge is one transfer.
  always @(posedge clk) begin
    if (s_ready !== clken) begin
      $display("MISMATCH at %0t ns: s_ready %0b while clken is %0b", $time, s_ready, clken);
      mismatches++;
    end
    if (!reset && m_valid === 1'b1) begin
      check_beat();
    end
  end

endmodule

/* dv/conv_engine_tb.sv */
// testbench for conv_engine; run from the project root so dv/conv_tests.txt is found.
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_engine_tb;

  localparam int          HALF_PERIOD   = 4;   // 8 ns clock.
  localparam int          RESET_CYCLES  = 3;
  localparam int          READY_TIMEOUT = 200; // cycles a beat may wait for s_ready.
  localparam int          DRAIN_TIMEOUT = 500; // cycles for the last results to show up.
  localparam logic [31:0] LCG_SEED      = 32'h91e7f76c;

  logic                                  clk;
  logic                                  clken;
  logic                                  reset;
  logic                                  s_valid;
  logic                                  s_cin_last;
  logic                                  s_last;
  logic [`CONV_UNITS*`CONV_WORD_IN-1:0]  s_pixels;
  logic [`CONV_WORD_IN-1:0]              s_weight;
  logic                                  s_ready;
  logic                                  m_valid;
  logic                                  m_last;
  logic [`CONV_UNITS*`CONV_WORD_OUT-1:0] m_data;

  logic [31:0] lcg_state;
  logic        stall_on;        // random clken drops enabled.
  int          timeouts = 0;
  int          file_errors = 0;
  int          mism;
  int          unexp;
  int          missing;

  conv_engine i_dut (
    .clk        (clk),
    .clken      (clken),
    .reset      (reset),
    .s_valid    (s_valid),
    .s_cin_last (s_cin_last),
    .s_last     (s_last),
    .s_pixels   (s_pixels),
    .s_weight   (s_weight),
    .s_ready    (s_ready),
    .m_valid    (m_valid),
    .m_last     (m_last),
    .m_data     (m_data)
  );

  conv_checker i_checker (
    .clk     (clk),
    .reset   (reset),
    .clken   (clken),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data)
  );

  always #HALF_PERIOD clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // falling edge, then pick clken for the coming rising edge.
  task automatic advance_clock();
    @(negedge clk);
    lcg_state = lcg_step(lcg_state);
    if (stall_on) begin
      clken = (lcg_state[31:30] != 2'b00); // low on about a quarter of cycles.
    end else begin
      clken = 1'b1;
    end
  endtask

  // drives one beat and holds it until a rising edge sees s_ready.
  task automatic send_beat(input logic valid, input logic cin_last, input logic last,
                           input logic [`CONV_WORD_IN-1:0] weight,
                           input logic [`CONV_UNITS*`CONV_WORD_IN-1:0] pixels);
    int waited;
    waited = 0;
    advance_clock();
    s_valid    = valid;
    s_cin_last = cin_last;
    s_last     = last;
    s_weight   = weight;
    s_pixels   = pixels;
    @(posedge clk);
    while (s_ready !== 1'b1) begin
      if (waited == READY_TIMEOUT) begin
        $display("timeout: beat not accepted within %0d cycles at %0t ns", waited, $time);
        timeouts++;
        break;
      end
      waited++;
      advance_clock(); // same beat, new clken draw.
      @(posedge clk);
    end
  endtask

  task automatic run_test_file();
    int                                    fd;
    int                                    code;
    int                                    rep;
    logic [7:0]                            kind;
    logic [8*256-1:0]                      line;
    logic                                  valid;
    logic                                  cin_last;
    logic                                  last;
    logic                                  stall;
    logic [`CONV_WORD_IN-1:0]              weight;
    logic [`CONV_WORD_IN-1:0]              pix [`CONV_UNITS];
    logic [`CONV_WORD_OUT-1:0]             sum [`CONV_UNITS];
    logic [`CONV_UNITS*`CONV_WORD_IN-1:0]  pixels;
    logic [`CONV_UNITS*`CONV_WORD_OUT-1:0] sums;
    fd = $fopen("dv/conv_tests.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open dv/conv_tests.txt");
      file_errors++;
    end else begin
      code = $fscanf(fd, " %c", kind);
      while (code == 1 && timeouts == 0 && file_errors == 0) begin
        case (kind)
          "#": code = $fgets(line, fd); // column notes.
          "S": begin
            code     = $fscanf(fd, "%h", stall);
            stall_on = stall;
          end
          "B": begin
            code = $fscanf(fd, "%d %h %h %h %h %h %h %h %h", rep, valid, cin_last, last,
                           weight, pix[0], pix[1], pix[2], pix[3]);
            if (code != 9) begin
              $display("error: malformed beat line in test file");
              file_errors++;
            end
            for (int u = 0; u < `CONV_UNITS; u++) begin
              pixels[u*`CONV_WORD_IN +: `CONV_WORD_IN] = pix[u];
            end
            // flags go on the final repeat only.
            for (int i = 0; i < rep && timeouts == 0 && file_errors == 0; i++) begin
              send_beat(valid, cin_last && (i == rep - 1), last && (i == rep - 1),
                        weight, pixels);
            end
          end
          "E": begin
            code = $fscanf(fd, "%h %h %h %h %h", last, sum[0], sum[1], sum[2], sum[3]);
            if (code != 5) begin
              $display("error: malformed expected line in test file");
              file_errors++;
            end
            for (int u = 0; u < `CONV_UNITS; u++) begin
              sums[u*`CONV_WORD_OUT +: `CONV_WORD_OUT] = sum[u];
            end
            i_checker.push_expected(last, sums);
          end
          default: begin
            $display("error: unknown line type '%c' in test file", kind);
            file_errors++;
          end
        endcase
        code = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
    end
  endtask

  // idles the inputs until every queued result has come out.
  task automatic drain_outputs();
    int waited;
    waited = 0;
    advance_clock(); // inputs only change on the falling edge.
    s_valid    = 1'b0;
    s_cin_last = 1'b0;
    s_last     = 1'b0;
    while (i_checker.pending_count() != 0) begin
      if (waited == DRAIN_TIMEOUT) begin
        $display("timeout: %0d results still pending after %0d cycles",
                 i_checker.pending_count(), waited);
        timeouts++;
        break;
      end
      waited++;
      advance_clock();
    end
    repeat (2 * `CONV_LAT_MUL + 2) advance_clock(); // catch stray extra beats.
  endtask

  initial begin
    clk        = 1'b0;
    clken      = 1'b1;
    reset      = 1'b1;
    s_valid    = 1'b0;
    s_cin_last = 1'b0;
    s_last     = 1'b0;
    s_pixels   = '0;
    s_weight   = '0;
    lcg_state  = LCG_SEED;
    stall_on   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    run_test_file();
    drain_outputs();
    i_checker.final_counts(mism, unexp, missing);
    $display("summary: %0d mismatch, %0d unexpected, %0d missing, %0d timeout, %0d file errors",
             mism, unexp, missing, timeouts, file_errors);
    if (mism + unexp + missing + timeouts + file_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* dv/conv_tests.txt */
# B rep valid cin_last last weight pix0 pix1 pix2 pix3 (rep decimal, rest hex, flags on final repeat).
# E last sum0 sum1 sum2 sum3 (24-bit hex); S 1 turns random clken stalls on, S 0 off.
S 0
B 1 1 0 0 02 01 02 03 04
B 2 0 0 0 00 00 00 00 00
B 1 1 0 0 ff 05 06 07 08
B 1 1 1 0 04 ff fe 10 00
E 0 fffff9 fffff6 00003f 000000
B 1 1 1 0 03 02 fe 7f 80
E 0 000006 fffffa 00017d fffe80
B 1 1 1 0 80 80 7f 01 00
E 0 004000 ffc080 ffff80 000000
B 1 1 1 0 7f 7f 80 ff 40
E 0 003f01 ffc080 ffff81 001fc0
B 1 1 0 0 0a 01 ff 02 fe
B 1 1 1 0 f7 01 ff 02 fe
E 0 000001 ffffff 000002 fffffe
B 1 1 0 0 01 0a ec 1e d8
B 1 1 0 0 02 0a ec 1e d8
B 1 1 0 0 03 0a ec 1e d8
B 1 1 0 0 fc 01 01 01 01
B 1 1 0 0 05 64 9c 00 7f
B 1 1 1 0 06 0a ec 1e d8
E 0 000268 fffd18 000164 000097
B 1 1 0 0 02 03 03 03 03
B 1 1 1 1 03 fd 01 00 80
E 1 fffffd 000009 000006 fffe86
B 1 1 1 0 01 01 02 03 04
E 0 000001 000002 000003 000004
S 1
B 1 1 0 0 02 01 02 03 04
B 1 1 0 0 ff 05 06 07 08
B 1 1 1 0 04 ff fe 10 00
E 0 fffff9 fffff6 00003f 000000
B 1 1 1 0 7f 7f 80 ff 40
E 0 003f01 ffc080 ffff81 001fc0
B 1 1 0 0 02 03 03 03 03
B 1 1 1 1 03 fd 01 00 80
E 1 fffffd 000009 000006 fffe86
B 1100 1 1 1 80 80 7f 01 ff
E 1 130000 ef2600 fdda00 022600
S 0
B 1 1 1 0 01 01 02 03 04
E 0 000001 000002 000003 000004

/* sim.f */
+incdir+logic
logic/conv_data_pkg.sv
logic/conv_ctrl_pkg.sv
logic/acc_ctrl_if.sv
logic/flag_delay.sv
logic/acc_sequencer.sv
logic/multiplier_array.sv
logic/accumulator_array.sv
logic/conv_engine.sv
dv/conv_checker.sv
dv/conv_engine_tb.sv
